// ==== rtl/ringPacketPkg.sv ====
`default_nettype none

package ringPacketPkg;

    localparam int packetWidth = 64;
    localparam int hopLsb      = 48;    // low bit of the hop field
    localparam int hopWidth    = 8;
    localparam int dirBit      = 62;    // injection direction for pe packets

    typedef enum logic {
        dirCw  = 1'b0,
        dirCcw = 1'b1
    } dir_e;

    // field widths follow from the positions above
    typedef struct packed {
        logic [packetWidth-dirBit-2:0]        spare;      // bit 63
        dir_e                                 dir;        // bit 62
        logic [dirBit-hopLsb-hopWidth-1:0]    reserved;   // bits 61..56
        logic [hopWidth-1:0]                  hop;        // bits 55..48
        logic [hopLsb-1:0]                    payload;    // bits 47..0
    } packet_t;

endpackage

`default_nettype wire

// ==== rtl/routerPkg.sv ====
`default_nettype none

package routerPkg;

    localparam int numVc   = 2;
    localparam int numChan = 3;

    // channel codes double as array indices in every stage
    typedef enum logic [1:0] {
        chanCw  = 2'd0,
        chanCcw = 2'd1,
        chanPe  = 2'd2
    } chan_e;

    typedef struct packed {
        logic                   send;
        ringPacketPkg::packet_t pkt;
    } linkIn_t;

    typedef struct packed {
        logic                   send;
        ringPacketPkg::packet_t pkt;
    } linkOut_t;

    // one buffer slot as seen by the allocator
    typedef struct packed {
        logic                   full;
        ringPacketPkg::packet_t pkt;
    } slot_t;

    // one write into an output slot
    typedef struct packed {
        logic                   write;
        ringPacketPkg::packet_t pkt;
    } xfer_t;

endpackage

`default_nettype wire

// ==== rtl/vcArbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module vcArbiter (
    input  logic clk,
    input  logic reset,
    input  logic polarity,
    input  logic req0,
    input  logic req1,
    output logic grant0,
    output logic grant1
);
    import routerPkg::*;

    logic [numVc-1:0] favor1;       // req1 has priority on this vc
    logic             curFavor1;
    logic             conflict;

    assign curFavor1 = favor1[polarity];
    assign conflict  = req0 & req1;

    always_comb begin
        grant0 = req0 & (~req1 | ~curFavor1);
        grant1 = req1 & (~req0 | curFavor1);
    end

    // the loser of a tie gets priority next time on this vc
    always_ff @(posedge clk) begin
        if (reset) begin
            favor1 <= '0;
        end else if (conflict) begin
            favor1[polarity] <= ~curFavor1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inputStage.sv ====
`default_nettype none
`timescale 1ns/1ps

module inputStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               polarity,
    input  routerPkg::linkIn_t cwIn,
    input  routerPkg::linkIn_t ccwIn,
    input  routerPkg::linkIn_t peIn,
    output logic               cwReady,
    output logic               ccwReady,
    output logic               peReady,
    output routerPkg::slot_t   slots [routerPkg::numChan][routerPkg::numVc],
    input  logic               readSlot [routerPkg::numChan][routerPkg::numVc]
);
    import routerPkg::*;
    import ringPacketPkg::*;

    logic    slotFull [numChan][numVc];
    packet_t slotData [numChan][numVc];
    logic    load     [numChan][numVc];
    linkIn_t links    [numChan];
    logic    ready    [numChan];
    logic    linkVc;

    assign linkVc = ~polarity;      // vc equal to polarity is busy inside

    assign links[chanCw]  = cwIn;
    assign links[chanCcw] = ccwIn;
    assign links[chanPe]  = peIn;

    assign cwReady  = ready[chanCw];
    assign ccwReady = ready[chanCcw];
    assign peReady  = ready[chanPe];

    always_comb begin
        for (int ch = 0; ch < numChan; ch++) begin
            ready[ch] = ~slotFull[ch][linkVc];      // link-facing slot is empty
            for (int vc = 0; vc < numVc; vc++) begin
                load[ch][vc]  = 1'b0;
                slots[ch][vc] = '{full: slotFull[ch][vc], pkt: slotData[ch][vc]};
            end
            load[ch][linkVc] = links[ch].send & ready[ch];
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < numChan; ch++) begin
            for (int vc = 0; vc < numVc; vc++) begin
                if (reset) begin
                    slotFull[ch][vc] <= 1'b0;
                end else if (load[ch][vc]) begin
                    slotFull[ch][vc] <= 1'b1;
                end else if (readSlot[ch][vc]) begin
                    slotFull[ch][vc] <= 1'b0;       // moved on to an output slot
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < numChan; ch++) begin
            for (int vc = 0; vc < numVc; vc++) begin
                if (load[ch][vc]) begin
                    slotData[ch][vc] <= links[ch].pkt;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/switchAllocator.sv ====
`default_nettype none
`timescale 1ns/1ps

module switchAllocator (
    input  logic             clk,
    input  logic             reset,
    output logic             polarity,
    input  routerPkg::slot_t slots [routerPkg::numChan][routerPkg::numVc],
    input  logic             outFull [routerPkg::numChan][routerPkg::numVc],
    output logic             readSlot [routerPkg::numChan][routerPkg::numVc],
    output routerPkg::xfer_t xfers [routerPkg::numChan][routerPkg::numVc]
);
    import routerPkg::*;
    import ringPacketPkg::*;

    slot_t   cur     [numChan];     // served slot of each input
    packet_t fwd     [numChan];     // same packet with the hop advanced
    chan_e   route   [numChan];     // target output of each input
    logic    outFree [numChan];
    logic    taken   [numChan];
    xfer_t   next    [numChan];     // write into each output slot

    logic reqCwCw, reqPeCw;
    logic reqCcwCcw, reqPeCcw;
    logic reqCwPe, reqCcwPe;
    logic grantCwCw, grantPeCw;
    logic grantCcwCcw, grantPeCcw;
    logic grantCwPe, grantCcwPe;

    always_ff @(posedge clk) begin
        if (reset) begin
            polarity <= 1'b0;
        end else begin
            polarity <= ~polarity;
        end
    end

    always_comb begin
        for (int ch = 0; ch < numChan; ch++) begin
            cur[ch]     = slots[ch][polarity];
            fwd[ch]     = cur[ch].pkt;
            fwd[ch].hop = cur[ch].pkt.hop >> 1;
            outFree[ch] = ~outFull[ch][polarity];
        end
    end

    // ring packets keep going while the hop low bit is set
    always_comb begin
        route[chanCw]  = cur[chanCw].pkt.hop[0] ? chanCw : chanPe;
        route[chanCcw] = cur[chanCcw].pkt.hop[0] ? chanCcw : chanPe;
        route[chanPe]  = (cur[chanPe].pkt.dir == dirCw) ? chanCw : chanCcw;
    end

    always_comb begin
        reqCwCw   = cur[chanCw].full && route[chanCw] == chanCw && outFree[chanCw];
        reqCwPe   = cur[chanCw].full && route[chanCw] == chanPe && outFree[chanPe];
        reqCcwCcw = cur[chanCcw].full && route[chanCcw] == chanCcw && outFree[chanCcw];
        reqCcwPe  = cur[chanCcw].full && route[chanCcw] == chanPe && outFree[chanPe];
        reqPeCw   = cur[chanPe].full && route[chanPe] == chanCw && outFree[chanCw];
        reqPeCcw  = cur[chanPe].full && route[chanPe] == chanCcw && outFree[chanCcw];
    end

    vcArbiter cwArbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCwCw),
        .req1     (reqPeCw),
        .grant0   (grantCwCw),
        .grant1   (grantPeCw)
    );

    vcArbiter ccwArbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCcwCcw),
        .req1     (reqPeCcw),
        .grant0   (grantCcwCcw),
        .grant1   (grantPeCcw)
    );

    vcArbiter peArbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCwPe),
        .req1     (reqCcwPe),
        .grant0   (grantCwPe),
        .grant1   (grantCcwPe)
    );

    always_comb begin
        taken[chanCw]  = grantCwCw | grantCwPe;
        taken[chanCcw] = grantCcwCcw | grantCcwPe;
        taken[chanPe]  = grantPeCw | grantPeCcw;

        next[chanCw]  = '{write: grantCwCw | grantPeCw,
                          pkt:   grantPeCw ? fwd[chanPe] : fwd[chanCw]};
        next[chanCcw] = '{write: grantCcwCcw | grantPeCcw,
                          pkt:   grantPeCcw ? fwd[chanPe] : fwd[chanCcw]};
        next[chanPe]  = '{write: grantCwPe | grantCcwPe,
                          pkt:   grantCcwPe ? fwd[chanCcw] : fwd[chanCw]};
    end

    // the link-facing vc stays idle here
    always_comb begin
        for (int ch = 0; ch < numChan; ch++) begin
            for (int vc = 0; vc < numVc; vc++) begin
                readSlot[ch][vc] = 1'b0;
                xfers[ch][vc]    = '0;
            end
            readSlot[ch][polarity] = taken[ch];
            xfers[ch][polarity]    = next[ch];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/outputStage.sv ====
`default_nettype none
`timescale 1ns/1ps

module outputStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                polarity,
    input  routerPkg::xfer_t    xfers [routerPkg::numChan][routerPkg::numVc],
    output logic                outFull [routerPkg::numChan][routerPkg::numVc],
    input  logic                cwOutReady,
    input  logic                ccwOutReady,
    input  logic                peOutReady,
    output routerPkg::linkOut_t cwOut,
    output routerPkg::linkOut_t ccwOut,
    output routerPkg::linkOut_t peOut
);
    import routerPkg::*;
    import ringPacketPkg::*;

    logic     slotFull [numChan][numVc];
    packet_t  slotData [numChan][numVc];
    logic     drain    [numChan][numVc];
    logic     outReady [numChan];
    linkOut_t links    [numChan];
    logic     linkVc;

    assign linkVc = ~polarity;

    assign outReady[chanCw]  = cwOutReady;
    assign outReady[chanCcw] = ccwOutReady;
    assign outReady[chanPe]  = peOutReady;

    assign cwOut  = links[chanCw];
    assign ccwOut = links[chanCcw];
    assign peOut  = links[chanPe];

    always_comb begin
        for (int ch = 0; ch < numChan; ch++) begin
            links[ch].send = slotFull[ch][linkVc] & outReady[ch];  // ready sampled first
            links[ch].pkt  = slotData[ch][linkVc];
            for (int vc = 0; vc < numVc; vc++) begin
                drain[ch][vc]   = 1'b0;
                outFull[ch][vc] = slotFull[ch][vc];
            end
            drain[ch][linkVc] = links[ch].send;
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < numChan; ch++) begin
            for (int vc = 0; vc < numVc; vc++) begin
                if (reset) begin
                    slotFull[ch][vc] <= 1'b0;
                end else if (xfers[ch][vc].write) begin
                    slotFull[ch][vc] <= 1'b1;
                end else if (drain[ch][vc]) begin
                    slotFull[ch][vc] <= 1'b0;       // empties on the send edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < numChan; ch++) begin
            for (int vc = 0; vc < numVc; vc++) begin
                if (xfers[ch][vc].write) begin
                    slotData[ch][vc] <= xfers[ch][vc].pkt;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ringRouter.sv ====
`default_nettype none
`timescale 1ns/1ps

module ringRouter (
    input  logic                clk,
    input  logic                reset,
    input  routerPkg::linkIn_t  cwIn,
    input  routerPkg::linkIn_t  ccwIn,
    input  routerPkg::linkIn_t  peIn,
    output logic                cwReady,
    output logic                ccwReady,
    output logic                peReady,
    output routerPkg::linkOut_t cwOut,
    output routerPkg::linkOut_t ccwOut,
    output routerPkg::linkOut_t peOut,
    input  logic                cwOutReady,
    input  logic                ccwOutReady,
    input  logic                peOutReady,
    output logic                polarity
);
    import routerPkg::*;

    slot_t slots    [numChan][numVc];   // input slots toward the allocator
    logic  readSlot [numChan][numVc];
    logic  outFull  [numChan][numVc];
    xfer_t xfers    [numChan][numVc];

    inputStage inputStage_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .cwIn     (cwIn),
        .ccwIn    (ccwIn),
        .peIn     (peIn),
        .cwReady  (cwReady),
        .ccwReady (ccwReady),
        .peReady  (peReady),
        .slots    (slots),
        .readSlot (readSlot)
    );

    switchAllocator switchAllocator_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .slots    (slots),
        .outFull  (outFull),
        .readSlot (readSlot),
        .xfers    (xfers)
    );

    outputStage outputStage_inst (
        .clk         (clk),
        .reset       (reset),
        .polarity    (polarity),
        .xfers       (xfers),
        .outFull     (outFull),
        .cwOutReady  (cwOutReady),
        .ccwOutReady (ccwOutReady),
        .peOutReady  (peOutReady),
        .cwOut       (cwOut),
        .ccwOut      (ccwOut),
        .peOut       (peOut)
    );

endmodule

`default_nettype wire

// ==== verif/ringRouter_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module ringRouter_asserts (
    input logic                clk,
    input logic                reset,
    input logic                polarity,
    input logic                cwOutReady,
    input logic                ccwOutReady,
    input logic                peOutReady,
    input routerPkg::linkOut_t cwOut,
    input routerPkg::linkOut_t ccwOut,
    input routerPkg::linkOut_t peOut
);

    // one full cycle out of reset before the toggle is expected
    polarityToggles: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> polarity != $past(polarity))
        else $error("polarity did not toggle");

    cwSendNeedsReady: assert property (@(posedge clk) disable iff (reset)
        !cwOutReady |-> !cwOut.send)
        else $error("cw send with ready low");

    ccwSendNeedsReady: assert property (@(posedge clk) disable iff (reset)
        !ccwOutReady |-> !ccwOut.send)
        else $error("ccw send with ready low");

    peSendNeedsReady: assert property (@(posedge clk) disable iff (reset)
        !peOutReady |-> !peOut.send)
        else $error("pe send with ready low");

endmodule

bind ringRouter ringRouter_asserts ringRouter_asserts_inst (
    .clk         (clk),
    .reset       (reset),
    .polarity    (polarity),
    .cwOutReady  (cwOutReady),
    .ccwOutReady (ccwOutReady),
    .peOutReady  (peOutReady),
    .cwOut       (cwOut),
    .ccwOut      (ccwOut),
    .peOut       (peOut)
);

`default_nettype wire

// ==== verif/ringRouterTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module ringRouterTb;
    import routerPkg::*;
    import ringPacketPkg::*;

    localparam int resetCycles = 16;
    localparam int drainLimit  = 400;   // cycles allowed for the router to empty

    typedef struct packed {
        chan_e   chan;
        packet_t pkt;
    } expect_t;

    logic     clk;
    logic     reset;
    linkIn_t  cwIn, ccwIn, peIn;
    logic     cwReady, ccwReady, peReady;
    linkOut_t cwOut, ccwOut, peOut;
    logic     cwOutReady, ccwOutReady, peOutReady;
    logic     polarity;

    logic [31:0] lfsr;
    expect_t     pending [$];           // accepted packets not yet seen on an output
    int          errors;
    int          delivered;
    int          testsRun;
    int          testsFailed;

    ringRouter ringRouter_inst (
        .clk         (clk),
        .reset       (reset),
        .cwIn        (cwIn),
        .ccwIn       (ccwIn),
        .peIn        (peIn),
        .cwReady     (cwReady),
        .ccwReady    (ccwReady),
        .peReady     (peReady),
        .cwOut       (cwOut),
        .ccwOut      (ccwOut),
        .peOut       (peOut),
        .cwOutReady  (cwOutReady),
        .ccwOutReady (ccwOutReady),
        .peOutReady  (peOutReady),
        .polarity    (polarity)
    );

    always #10 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic randomBit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic linkIn_t randomLink();
        linkIn_t          link;
        logic [63:0]      bits;
        bits = '0;
        link.send = randomBit();
        for (int i = 0; i < packetWidth; i++) begin
            bits = {bits[62:0], randomBit()};
        end
        link.pkt = packet_t'(bits);
        return link;
    endfunction

    // ring packets continue on a set hop bit and pe packets follow dir
    function automatic expect_t routeModel(input chan_e inChan, input packet_t pkt);
        expect_t e;
        e.pkt     = pkt;
        e.pkt.hop = {1'b0, pkt.hop[hopWidth-1:1]};
        if (inChan == chanPe) begin
            e.chan = (pkt.dir == dirCcw) ? chanCcw : chanCw;
        end else if (pkt.hop[0]) begin
            e.chan = inChan;
        end else begin
            e.chan = chanPe;
        end
        return e;
    endfunction

    task automatic acceptInput(input chan_e ch, input linkIn_t link, input logic ready);
        if (link.send && ready) begin
            pending.push_back(routeModel(ch, link.pkt));
        end
    endtask

    task automatic checkOutput(input chan_e ch, input linkOut_t link, input logic ready);
        int hit;
        hit = -1;
        if (link.send) begin
            if (!ready) begin
                $display("ERROR at %0t: %s send while its ready is low", $time, ch.name());
                errors++;
            end
            foreach (pending[i]) begin
                if (hit < 0 && pending[i].chan == ch && pending[i].pkt == link.pkt) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                $display("ERROR at %0t: unexpected packet %h on %s", $time, link.pkt, ch.name());
                errors++;
            end else begin
                pending.delete(hit);
                delivered++;
            end
        end
    endtask

    // values here are the ones the next rising edge will see
    always @(negedge clk) begin
        if (!reset) begin
            acceptInput(chanCw, cwIn, cwReady);
            acceptInput(chanCcw, ccwIn, ccwReady);
            acceptInput(chanPe, peIn, peReady);
            checkOutput(chanCw, cwOut, cwOutReady);
            checkOutput(chanCcw, ccwOut, ccwOutReady);
            checkOutput(chanPe, peOut, peOutReady);
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitDrain();
        int cycles;
        stepCycle();
        cwIn.send   = 1'b0;
        ccwIn.send  = 1'b0;
        peIn.send   = 1'b0;
        cwOutReady  = 1'b1;
        ccwOutReady = 1'b1;
        peOutReady  = 1'b1;
        cycles = 0;
        while (pending.size() != 0 && cycles < drainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (pending.size() != 0) begin
            $display("timeout: %0d expected packets were never delivered", pending.size());
            errors++;
            pending.delete();
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    initial begin
        int   errBefore;
        int   cycles;
        logic expPol;
        logic dropped;
        clk = 1'b0;
        reset = 1'b1;
        cwIn = '0;
        ccwIn = '0;
        peIn = '0;
        cwOutReady = 1'b1;
        ccwOutReady = 1'b1;
        peOutReady = 1'b1;
        lfsr = 32'd93784;
        errors = 0;
        delivered = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;

        errBefore = errors;
        @(negedge clk);
        if (!(cwReady && ccwReady && peReady) || cwOut.send || ccwOut.send || peOut.send) begin
            $display("ERROR at %0t: readies %b%b%b sends %b%b%b after reset", $time,
                     cwReady, ccwReady, peReady, cwOut.send, ccwOut.send, peOut.send);
            errors++;
        end
        expPol = 1'b0;                      // reset leaves polarity low
        repeat (7) begin
            if (polarity !== expPol) begin
                $display("ERROR at %0t: polarity %b, expected %b", $time, polarity, expPol);
                errors++;
            end
            expPol = ~expPol;
            @(negedge clk);
        end
        finishTest("reset", errBefore);

        errBefore = errors;
        repeat (200) begin
            stepCycle();
            cwIn  = randomLink();
            ccwIn = randomLink();
        end
        waitDrain();
        finishTest("ring forward and eject", errBefore);

        errBefore = errors;
        repeat (200) begin
            stepCycle();
            peIn = randomLink();
        end
        waitDrain();
        finishTest("pe injection", errBefore);

        errBefore = errors;
        repeat (300) begin
            stepCycle();
            cwIn            = randomLink();
            cwIn.pkt.hop[0] = 1'b1;     // stays on the ring
            peIn            = randomLink();
            peIn.pkt.dir    = dirCw;
            cwOutReady      = randomBit();
        end
        waitDrain();
        finishTest("cw contention", errBefore);

        errBefore = errors;
        stepCycle();
        cwOutReady = 1'b0;
        dropped = 1'b0;
        cycles = 0;
        while (!dropped && cycles < 50) begin
            stepCycle();
            cwIn            = randomLink();
            cwIn.send       = 1'b1;
            cwIn.pkt.hop[0] = 1'b1;
            @(negedge clk);
            dropped = ~cwReady;
            cycles++;
        end
        if (!dropped) begin
            $display("timeout: cwReady never dropped while cwOutReady was held low");
            errors++;
        end
        repeat (8) begin
            stepCycle();
            cwIn.send = 1'b0;
            @(negedge clk);
            if (cwOut.send) begin
                $display("ERROR at %0t: cwOut send while held", $time);
                errors++;
            end
        end
        waitDrain();
        finishTest("back-pressure", errBefore);

        $display("tests %0d, failed %0d, packets checked %0d, errors %0d",
                 testsRun, testsFailed, delivered, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/ringPacketPkg.sv
rtl/routerPkg.sv
rtl/vcArbiter.sv
rtl/inputStage.sv
rtl/switchAllocator.sv
rtl/outputStage.sv
rtl/ringRouter.sv
verif/ringRouter_asserts.sv
verif/ringRouterTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ringRouterTb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
